// File: ddr_wr_pkg.sv
// shared definitions for the DDR2 write PHY
//   burst geometry constants
//   beat pair select type and its two values
//   write controller state encoding
//   control word from the controller to the datapaths
`default_nettype none

package ddr_wr_pkg;

	// ********************
	// burst geometry
	// ********************

	// DDR2 burst length 4
	localparam int BEATS_PER_BURST = 4;
	// two beats per clk, one per clk phase
	localparam int BEATS_PER_CLK = 2;

	// which beat pair goes out in a data cycle
	typedef logic [0:0] beat_pair_t;

	// beats 0 and 1
	localparam beat_pair_t BEAT_PAIR_LO = 1'b0;
	// beats 2 and 3
	localparam beat_pair_t BEAT_PAIR_HI = 1'b1;

	// ********************
	// controller types
	// ********************

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_PREAMBLE  = 3'd1,
		ST_DATA0     = 3'd2,
		ST_DATA1     = 3'd3,
		ST_POSTAMBLE = 3'd4
	} wr_state_t;

	// enables describe the pin cycle that follows
	typedef struct packed {
		logic       load;
		beat_pair_t beat_sel;
		logic       dq_en;
		logic       dqs_en;
		logic       dqs_run;
	} phy_ctrl_t;

endpackage

`default_nettype wire

// File: ddr_ddio_out.sv
// soft-logic double data rate output register
//   rising-edge capture of a two-beat word
//   asynchronous reset to all ones or all zeros
//   clk-driven mux, low beat in the high phase, high beat in the low phase
`timescale 1ns/1ps
`default_nettype none

module ddr_ddio_out #(
	parameter int WIDTH      = 1,
	parameter bit RESET_HIGH = 1'b0
) (
	input  wire                                     clk,
	input  wire                                     dr_reset_n,
	// {second beat, first beat}
	input  wire [ddr_wr_pkg::BEATS_PER_CLK*WIDTH-1:0] datain,
	output logic [WIDTH-1:0]                        dataout
);

	import ddr_wr_pkg::*;

	// ********************
	// word register
	// ********************

	localparam int IN_WIDTH = BEATS_PER_CLK * WIDTH;

	// value the pin shows while in reset and just after
	localparam logic [IN_WIDTH-1:0] RESET_WORD = {IN_WIDTH{RESET_HIGH}};

	// both beats of the current clk cycle
	logic [IN_WIDTH-1:0] word_q;

	// one register for both phases
	// so every pin built from this block has the same phase relation to clk
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			word_q <= RESET_WORD;
		end else begin
			word_q <= datain;
		end
	end

	// ********************
	// phase mux
	// ********************

	// first beat while clk is high
	// second beat while clk is low
	// the low phase still sees the word loaded on the preceding rising edge
	always_comb begin
		if (clk) begin
			dataout = word_q[0 +: WIDTH];
		end else begin
			dataout = word_q[WIDTH +: WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: ddr_wr_ctrl.sv
// write burst controller
//   state machine idle, preamble, two data cycles, postamble
//   request accept and burst capture strobe
//   registered busy level and wr_done pulse
//   registered enables for the DQ and DQS datapaths
`timescale 1ns/1ps
`default_nettype none

module ddr_wr_ctrl (
	input  wire                   clk,
	input  wire                   dr_reset_n,
	input  wire                   wr_req,
	output logic                  busy,
	output logic                  wr_done,
	output ddr_wr_pkg::phy_ctrl_t ctrl
);

	import ddr_wr_pkg::*;

	// ********************
	// state machine
	// ********************

	wr_state_t state;
	wr_state_t state_next;

	// a request only counts in idle
	// anything seen while a burst runs is dropped here
	logic accept;

	assign accept = wr_req && (state == ST_IDLE);

	// one step per clk once started, no waits
	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (accept) begin
					state_next = ST_PREAMBLE;
				end
			end
			ST_PREAMBLE: begin
				state_next = ST_DATA0;
			end
			ST_DATA0: begin
				state_next = ST_DATA1;
			end
			ST_DATA1: begin
				state_next = ST_POSTAMBLE;
			end
			ST_POSTAMBLE: begin
				state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	// ********************
	// enable decode
	// ********************

	// decoded from the state being entered
	// the datapaths add one register, so each pin follows its state by one cycle
	logic       dq_en_next;
	logic       dqs_en_next;
	logic       dqs_run_next;
	beat_pair_t beat_sel_next;

	always_comb begin
		dq_en_next    = 1'b0;
		dqs_en_next   = 1'b0;
		dqs_run_next  = 1'b0;
		beat_sel_next = BEAT_PAIR_LO;
		case (state_next)
			// strobe driven low, no data yet
			ST_PREAMBLE, ST_POSTAMBLE: begin
				dqs_en_next = 1'b1;
			end
			ST_DATA0: begin
				dq_en_next   = 1'b1;
				dqs_en_next  = 1'b1;
				dqs_run_next = 1'b1;
			end
			ST_DATA1: begin
				dq_en_next    = 1'b1;
				dqs_en_next   = 1'b1;
				dqs_run_next  = 1'b1;
				beat_sel_next = BEAT_PAIR_HI;
			end
			default: begin
				dq_en_next = 1'b0;
			end
		endcase
	end

	// ********************
	// registers
	// ********************

	logic       dq_en_q;
	logic       dqs_en_q;
	logic       dqs_run_q;
	beat_pair_t beat_sel_q;

	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			state      <= ST_IDLE;
			busy       <= 1'b0;
			wr_done    <= 1'b0;
			dq_en_q    <= 1'b0;
			dqs_en_q   <= 1'b0;
			dqs_run_q  <= 1'b0;
			beat_sel_q <= BEAT_PAIR_LO;
		end else begin
			state      <= state_next;
			// high from the preamble state until back in idle
			busy       <= (state_next != ST_IDLE);
			// same cycle as the last beat pair on the pins
			wr_done    <= (state_next == ST_POSTAMBLE);
			dq_en_q    <= dq_en_next;
			dqs_en_q   <= dqs_en_next;
			dqs_run_q  <= dqs_run_next;
			beat_sel_q <= beat_sel_next;
		end
	end

	// load is the accept itself
	// so the burst is taken on the same edge as the request
	assign ctrl = '{
		load:     accept,
		beat_sel: beat_sel_q,
		dq_en:    dq_en_q,
		dqs_en:   dqs_en_q,
		dqs_run:  dqs_run_q
	};

endmodule

`default_nettype wire

// File: ddr_dq_path.sv
// DQ and DM datapath
//   burst holding register loaded on ctrl.load
//   beat pair select for each data cycle
//   DDR output registers for DQ and DM
//   DQ output enable aligned to the DDR output
`timescale 1ns/1ps
`default_nettype none

module ddr_dq_path #(
	parameter int DATA_WIDTH = 8,
	parameter bit RESET_HIGH = 1'b0
) (
	input  wire                                                clk,
	input  wire                                                dr_reset_n,
	input  wire ddr_wr_pkg::phy_ctrl_t                         ctrl,
	input  wire [DATA_WIDTH*ddr_wr_pkg::BEATS_PER_BURST-1:0]    wr_data,
	input  wire [(DATA_WIDTH/8)*ddr_wr_pkg::BEATS_PER_BURST-1:0] wr_mask,
	output logic [DATA_WIDTH-1:0]                              dq,
	output logic [DATA_WIDTH/8-1:0]                            dm,
	output logic                                               dq_oe
);

	import ddr_wr_pkg::*;

	// one DM bit per byte lane
	localparam int DM_WIDTH = DATA_WIDTH / 8;
	localparam int DQ_PAIR  = DATA_WIDTH * BEATS_PER_CLK;
	localparam int DM_PAIR  = DM_WIDTH * BEATS_PER_CLK;

	// ********************
	// burst capture
	// ********************

	// host may change wr_data once the burst is taken
	logic [DATA_WIDTH*BEATS_PER_BURST-1:0] data_q;
	logic [DM_WIDTH*BEATS_PER_BURST-1:0]   mask_q;

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			data_q <= wr_data;
			mask_q <= wr_mask;
		end
	end

	// ********************
	// beat pair select
	// ********************

	// beat 0 sits lowest, so a pair slice is already {second, first}
	// outside data cycles the pins park at their reset level
	logic [DQ_PAIR-1:0] dq_pair;
	logic [DM_PAIR-1:0] dm_pair;

	always_comb begin
		if (ctrl.dq_en) begin
			dq_pair = data_q[int'(ctrl.beat_sel) * DQ_PAIR +: DQ_PAIR];
			dm_pair = mask_q[int'(ctrl.beat_sel) * DM_PAIR +: DM_PAIR];
		end else begin
			dq_pair = {DQ_PAIR{RESET_HIGH}};
			dm_pair = {DM_PAIR{RESET_HIGH}};
		end
	end

	ddr_ddio_out #(
		.WIDTH      (DATA_WIDTH),
		.RESET_HIGH (RESET_HIGH)
	) u_dq_ddio (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dq_pair),
		.dataout    (dq)
	);

	ddr_ddio_out #(
		.WIDTH      (DM_WIDTH),
		.RESET_HIGH (RESET_HIGH)
	) u_dm_ddio (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dm_pair),
		.dataout    (dm)
	);

	// same stage as the DDIO word register
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			dq_oe <= 1'b0;
		end else begin
			dq_oe <= ctrl.dq_en;
		end
	end

endmodule

`default_nettype wire

// File: ddr_dqs_gen.sv
// DQS strobe generator
//   high-then-low pair per data cycle, low otherwise
//   DDR output register for the strobe pin
//   DQS output enable covering preamble, data and postamble
`timescale 1ns/1ps
`default_nettype none

module ddr_dqs_gen #(
	parameter bit RESET_HIGH = 1'b0
) (
	input  wire                        clk,
	input  wire                        dr_reset_n,
	input  wire ddr_wr_pkg::phy_ctrl_t ctrl,
	output logic                       dqs,
	output logic                       dqs_oe
);

	import ddr_wr_pkg::*;

	// ********************
	// strobe pattern
	// ********************

	// {second beat, first beat}
	// high while clk is high, edges line up with the DQ beats
	localparam logic [BEATS_PER_CLK-1:0] DQS_TOGGLE = 2'b01;
	// preamble and postamble hold the strobe low
	localparam logic [BEATS_PER_CLK-1:0] DQS_LOW    = 2'b00;

	logic [BEATS_PER_CLK-1:0] dqs_pair;

	assign dqs_pair = ctrl.dqs_run ? DQS_TOGGLE : DQS_LOW;

	ddr_ddio_out #(
		.WIDTH      (1),
		.RESET_HIGH (RESET_HIGH)
	) u_dqs_ddio (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.datain     (dqs_pair),
		.dataout    (dqs)
	);

	// ********************
	// output enable
	// ********************

	// one stage, same as the strobe register
	always_ff @(posedge clk or negedge dr_reset_n) begin
		if (!dr_reset_n) begin
			dqs_oe <= 1'b0;
		end else begin
			dqs_oe <= ctrl.dqs_en;
		end
	end

endmodule

`default_nettype wire

// File: ddr_wr_phy.sv
// DDR2 write PHY top level
//   write controller
//   DQ and DM datapath
//   DQS generator
`timescale 1ns/1ps
`default_nettype none

module ddr_wr_phy #(
	parameter int DATA_WIDTH = 8,
	parameter bit RESET_HIGH = 1'b0
) (
	input  wire                                                clk,
	input  wire                                                dr_reset_n,
	// host side
	input  wire                                                wr_req,
	input  wire [DATA_WIDTH*ddr_wr_pkg::BEATS_PER_BURST-1:0]    wr_data,
	input  wire [(DATA_WIDTH/8)*ddr_wr_pkg::BEATS_PER_BURST-1:0] wr_mask,
	output logic                                               busy,
	output logic                                               wr_done,
	// pin side
	output logic [DATA_WIDTH-1:0]                              dq,
	output logic [DATA_WIDTH/8-1:0]                            dm,
	output logic                                               dq_oe,
	output logic                                               dqs,
	output logic                                               dqs_oe
);

	import ddr_wr_pkg::*;

	// single source, both datapaths only listen
	phy_ctrl_t ctrl;

	ddr_wr_ctrl u_ctrl (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_req     (wr_req),
		.busy       (busy),
		.wr_done    (wr_done),
		.ctrl       (ctrl)
	);

	// wr_data and wr_mask go straight in, taken on ctrl.load
	ddr_dq_path #(
		.DATA_WIDTH (DATA_WIDTH),
		.RESET_HIGH (RESET_HIGH)
	) u_dq_path (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.ctrl       (ctrl),
		.wr_data    (wr_data),
		.wr_mask    (wr_mask),
		.dq         (dq),
		.dm         (dm),
		.dq_oe      (dq_oe)
	);

	ddr_dqs_gen #(
		.RESET_HIGH (RESET_HIGH)
	) u_dqs_gen (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.ctrl       (ctrl),
		.dqs        (dqs),
		.dqs_oe     (dqs_oe)
	);

endmodule

`default_nettype wire

// File: ddr_wr_assertions.sv
// pin-level checker for the DDR2 write PHY
//   DQ enable only inside the DQS enable window
//   host outputs quiet during reset
//   wr_done one cycle wide
//   strobe low in preamble and postamble
`timescale 1ns/1ps
`default_nettype none

module ddr_wr_assertions (
	input wire clk,
	input wire dr_reset_n,
	input wire busy,
	input wire wr_done,
	input wire dq_oe,
	input wire dqs_oe,
	input wire dqs
);

	// ********************
	// pin rules
	// ********************

	// data never driven without a strobe
	dq_oe_in_dqs_window: assert property (
		@(posedge clk) disable iff (!dr_reset_n) dq_oe |-> dqs_oe
	) else $error("dq_oe high while dqs_oe is low");

	reset_keeps_host_quiet: assert property (
		@(posedge clk) !dr_reset_n |-> (!busy && !wr_done)
	) else $error("busy or wr_done high during reset");

	wr_done_one_cycle: assert property (
		@(posedge clk) disable iff (!dr_reset_n) wr_done |=> !wr_done
	) else $error("wr_done longer than one cycle");

	// preamble and postamble
	dqs_low_outside_data: assert property (
		@(posedge clk) disable iff (!dr_reset_n) (dqs_oe && !dq_oe) |-> !dqs
	) else $error("dqs high in preamble or postamble");

endmodule

bind ddr_wr_phy ddr_wr_assertions u_wr_assertions (
	.clk        (clk),
	.dr_reset_n (dr_reset_n),
	.busy       (busy),
	.wr_done    (wr_done),
	.dq_oe      (dq_oe),
	.dqs_oe     (dqs_oe),
	.dqs        (dqs)
);

`default_nettype wire

// File: tb_ddr_wr_phy.sv
// directed testbench for the DDR2 write PHY
//   clock, reset and a seeded LCG for burst data and masks
//   request driver and pin-side burst checker
//   tests for reset state, single burst, capture and drop, back-to-back bursts
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_wr_phy;

	import ddr_wr_pkg::*;

	// ********************
	// setup
	// ********************

	localparam int  DW           = 8;
	localparam int  DM_W         = DW / 8;
	localparam int  DATA_BITS    = DW * BEATS_PER_BURST;
	localparam int  MASK_BITS    = DM_W * BEATS_PER_BURST;
	localparam real CLK_PERIOD   = 4.0;
	localparam int  RESET_CYCLES = 16;
	// cycles from the request edge to the first beat on the pins
	localparam int  LATENCY      = 3;
	localparam int  WAIT_LIMIT   = 50;
	localparam int  QUIET_CYCLES = 6;
	localparam int  NUM_B2B      = 20;
	localparam logic [31:0] LCG_SEED = 32'd61264;

	logic                 clk;
	logic                 dr_reset_n;
	logic                 wr_req;
	logic [DATA_BITS-1:0] wr_data;
	logic [MASK_BITS-1:0] wr_mask;
	logic                 busy;
	logic                 wr_done;
	logic [DW-1:0]        dq;
	logic [DM_W-1:0]      dm;
	logic                 dq_oe;
	logic                 dqs;
	logic                 dqs_oe;

	logic [31:0] lcg_state;
	int unsigned cycle_cnt = 0;
	// edge count at each accepted request, oldest first
	int unsigned req_q[$];

	ddr_wr_phy #(
		.DATA_WIDTH (DW),
		.RESET_HIGH (1'b0)
	) DUT (
		.clk        (clk),
		.dr_reset_n (dr_reset_n),
		.wr_req     (wr_req),
		.wr_data    (wr_data),
		.wr_mask    (wr_mask),
		.busy       (busy),
		.wr_done    (wr_done),
		.dq         (dq),
		.dm         (dm),
		.dq_oe      (dq_oe),
		.dqs        (dqs),
		.dqs_oe     (dqs_oe)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2.0) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ********************
	// helpers
	// ********************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// upper LCG bits are the better ones
	function automatic logic [DATA_BITS-1:0] gen_data();
		logic [31:0]          r;
		logic [DATA_BITS-1:0] d;
		for (int k = 0; k < BEATS_PER_BURST; k++) begin
			r = lcg_next();
			d[k*DW +: DW] = r[31 -: DW];
		end
		return d;
	endfunction

	function automatic logic [MASK_BITS-1:0] gen_mask();
		logic [31:0]          r;
		logic [MASK_BITS-1:0] m;
		for (int k = 0; k < BEATS_PER_BURST; k++) begin
			r = lcg_next();
			m[k*DM_W +: DM_W] = r[31 -: DM_W];
		end
		return m;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
				name, actual, expected));
		end
	endtask

	// all host and pin outputs at their reset level
	task automatic check_idle_pins(input string phase);
		check_value({"busy ", phase}, 32'(busy), 32'd0);
		check_value({"wr_done ", phase}, 32'(wr_done), 32'd0);
		check_value({"dq_oe ", phase}, 32'(dq_oe), 32'd0);
		check_value({"dqs_oe ", phase}, 32'(dqs_oe), 32'd0);
		check_value({"dq ", phase}, 32'(dq), 32'd0);
		check_value({"dm ", phase}, 32'(dm), 32'd0);
		check_value({"dqs ", phase}, 32'(dqs), 32'd0);
	endtask

	// called at edge + 0.5 ns, returns there too
	task automatic wait_idle();
		int n;
		n = 0;
		while (busy) begin
			@(posedge clk);
			#0.5;
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: busy never went low");
			end
		end
	endtask

	// ********************
	// driver and checker
	// ********************

	task automatic send_burst(input logic [DATA_BITS-1:0] data,
			input logic [MASK_BITS-1:0] mask, input bit scramble, input bit extra_req);
		wait_idle();
		wr_req  = 1'b1;
		wr_data = data;
		wr_mask = mask;
		req_q.push_back(cycle_cnt);
		@(posedge clk);
		#0.5;
		wr_req = 1'b0;
		check_value("busy after request", 32'(busy), 32'd1);
		// burst is already held inside, host bus is free again
		if (scramble) begin
			wr_data = gen_data();
			wr_mask = gen_mask();
		end
		// this one lands in the middle of the burst and must be dropped
		if (extra_req) begin
			@(posedge clk);
			#0.5;
			check_value("busy before extra request", 32'(busy), 32'd1);
			wr_req = 1'b1;
			@(posedge clk);
			#0.5;
			wr_req = 1'b0;
		end
	endtask

	// samples at mid high phase (edge + 1) and mid low phase (edge + 3)
	task automatic check_burst(input logic [DATA_BITS-1:0] data,
			input logic [MASK_BITS-1:0] mask);
		int          n;
		int          k;
		int unsigned req_cyc;
		logic        early_oe;
		logic        pre_oe;
		logic        pre_hi;
		logic        pre_lo;
		n        = 0;
		early_oe = 1'b0;
		pre_oe   = 1'b0;
		pre_hi   = 1'b1;
		pre_lo   = 1'b1;
		@(posedge clk);
		#1;
		while (!dq_oe) begin
			// remember the cycle before data, it has to be the preamble
			// and the one before that has no strobe enable yet
			early_oe = pre_oe;
			pre_oe   = dqs_oe;
			pre_hi   = dqs;
			#2;
			pre_lo = dqs;
			n++;
			if (n > WAIT_LIMIT) begin
				abort_run("timeout: dq_oe never went high");
			end
			@(posedge clk);
			#1;
		end
		if (req_q.size() == 0) begin
			abort_run("dq_oe went high without any accepted request");
		end
		req_cyc = req_q.pop_front();
		check_value("latency", 32'(cycle_cnt - req_cyc), 32'(LATENCY));
		check_value("dqs_oe before preamble", 32'(early_oe), 32'd0);
		check_value("dqs_oe preamble", 32'(pre_oe), 32'd1);
		check_value("dqs preamble high", 32'(pre_hi), 32'd0);
		check_value("dqs preamble low", 32'(pre_lo), 32'd0);
		// two data cycles, one beat pair each
		for (int p = 0; p < BEATS_PER_BURST / BEATS_PER_CLK; p++) begin
			k = p * BEATS_PER_CLK;
			check_value($sformatf("dq beat %0d", k), 32'(dq), 32'(data[k*DW +: DW]));
			check_value($sformatf("dm beat %0d", k), 32'(dm), 32'(mask[k*DM_W +: DM_W]));
			check_value("dqs data high", 32'(dqs), 32'd1);
			check_value("dqs_oe data", 32'(dqs_oe), 32'd1);
			check_value("busy data", 32'(busy), 32'd1);
			// wr_done marks the last pair
			check_value("wr_done data", 32'(wr_done), 32'(p == 1));
			#2;
			k = k + 1;
			check_value($sformatf("dq beat %0d", k), 32'(dq), 32'(data[k*DW +: DW]));
			check_value($sformatf("dm beat %0d", k), 32'(dm), 32'(mask[k*DM_W +: DM_W]));
			check_value("dqs data low", 32'(dqs), 32'd0);
			check_value("dq_oe data", 32'(dq_oe), 32'd1);
			@(posedge clk);
			#1;
		end
		// postamble
		check_value("dq_oe postamble", 32'(dq_oe), 32'd0);
		check_value("dqs_oe postamble", 32'(dqs_oe), 32'd1);
		check_value("dqs postamble high", 32'(dqs), 32'd0);
		check_value("busy postamble", 32'(busy), 32'd0);
		check_value("wr_done postamble", 32'(wr_done), 32'd0);
		#2;
		check_value("dqs postamble low", 32'(dqs), 32'd0);
		@(posedge clk);
		#1;
		check_value("dqs_oe after postamble", 32'(dqs_oe), 32'd0);
	endtask

	// ********************
	// tests
	// ********************

	task automatic test_reset_state();
		dr_reset_n = 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		#1;
		check_idle_pins("in reset, clk high");
		#2;
		check_idle_pins("in reset, clk low");
		@(posedge clk);
		#0.5;
		dr_reset_n = 1'b1;
		@(posedge clk);
		#1;
		check_idle_pins("after reset, clk high");
		#2;
		check_idle_pins("after reset, clk low");
	endtask

	task automatic test_single_burst();
		logic [DATA_BITS-1:0] d;
		logic [MASK_BITS-1:0] m;
		d = gen_data();
		m = gen_mask();
		@(posedge clk);
		#0.5;
		fork
			send_burst(d, m, 1'b0, 1'b0);
			check_burst(d, m);
		join
	endtask

	task automatic test_capture_and_drop();
		logic [DATA_BITS-1:0] d;
		logic [MASK_BITS-1:0] m;
		d = gen_data();
		m = gen_mask();
		@(posedge clk);
		#0.5;
		fork
			send_burst(d, m, 1'b1, 1'b1);
			check_burst(d, m);
		join
		// nothing may follow the dropped request
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(posedge clk);
			#1;
			check_value("busy after dropped request", 32'(busy), 32'd0);
			check_value("dq_oe after dropped request", 32'(dq_oe), 32'd0);
			check_value("dqs_oe after dropped request", 32'(dqs_oe), 32'd0);
		end
	endtask

	task automatic test_back_to_back();
		logic [DATA_BITS-1:0] d [NUM_B2B];
		logic [MASK_BITS-1:0] m [NUM_B2B];
		for (int i = 0; i < NUM_B2B; i++) begin
			d[i] = gen_data();
			m[i] = gen_mask();
		end
		@(posedge clk);
		#0.5;
		// next request goes out on the cycle busy drops
		fork
			begin
				for (int i = 0; i < NUM_B2B; i++) begin
					send_burst(d[i], m[i], 1'b0, 1'b0);
				end
			end
			begin
				for (int i = 0; i < NUM_B2B; i++) begin
					check_burst(d[i], m[i]);
				end
			end
		join
	endtask

	initial begin
		wr_req     = 1'b0;
		wr_data    = '0;
		wr_mask    = '0;
		dr_reset_n = 1'b0;
		lcg_state  = LCG_SEED;
		test_reset_state();
		test_single_burst();
		test_capture_and_drop();
		test_back_to_back();
		@(posedge clk);
		#1;
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
ddr_wr_pkg.sv
ddr_ddio_out.sv
ddr_wr_ctrl.sv
ddr_dq_path.sv
ddr_dqs_gen.sv
ddr_wr_phy.sv
ddr_wr_assertions.sv
tb_ddr_wr_phy.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the DDR2 write PHY testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_ddr_wr_phy \
	-f tb.f

status=0
./obj_dir/Vtb_ddr_wr_phy > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed (exit status ${status})"
	exit 0
else
	echo "simulation failed (exit status ${status})"
	exit 1
fi
